// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_c16_input
FILELIST := c16_input.f
OBJ_DIR  := obj_dir

BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: c16_input.f
hdl/c16_bus_pkg.sv
hdl/c16_key_pkg.sv
hdl/ps2_receiver.sv
hdl/key_matrix.sv
hdl/keyport_6529.sv
hdl/kbus_latch.sv
hdl/reset_stretch.sv
hdl/c16_input.sv
test/clk_gen.sv
test/tb_c16_input.sv

// File: hdl/c16_bus_pkg.sv
package c16_bus_pkg;

	////////////////////////////////////////////////////////////
	// CPU bus geometry
	////////////////////////////////////////////////////////////

	// Full 6502 style address space
	localparam int ADDR_W = 16;

	// Byte wide data bus
	localparam int DATA_W = 8;

	////////////////////////////////////////////////////////////
	// Decoded I/O locations
	////////////////////////////////////////////////////////////

	// Keyport sits on $FD30..$FD3F, only the upper twelve bits are decoded
	localparam logic [ADDR_W-5:0] KEYPORT_PAGE = 12'hFD3;

	// TED keyboard latch, written to select joysticks, read to get the K lines
	localparam logic [ADDR_W-1:0] KBD_LATCH_ADDR = 16'hFF08;

	// Roughly half a second at 28 MHz, close to the RC reset of the real board
	localparam int unsigned RESET_CYCLES_DEF = 32'd1 << 24;

endpackage

// File: hdl/c16_input.sv
`timescale 1ns/100ps

module c16_input #(
	parameter int unsigned RESET_CYCLES = c16_bus_pkg::RESET_CYCLES_DEF
) (
	input  logic                            CLK28,
	input  logic                            rst,
	input  logic                            ps2_clk,
	input  logic                            ps2_data,
	input  logic [4:0]                      joy0,
	input  logic [4:0]                      joy1,
	input  logic [c16_bus_pkg::ADDR_W-1:0] addr,
	input  logic [c16_bus_pkg::DATA_W-1:0] wdata,
	input  logic                            rw,
	input  logic                            bus_strobe,
	output logic [c16_bus_pkg::DATA_W-1:0] rdata,
	output logic                            sys_reset,
	output logic [c16_bus_pkg::DATA_W-1:0] kbus
);
	import c16_bus_pkg::*;

	logic              rx_done;
	logic [7:0]        scancode;
	logic [DATA_W-1:0] row_sel;
	logic [7:0]        kbus_kbd;
	logic              keyreset;
	logic [DATA_W-1:0] keyport_rdata;
	logic [DATA_W-1:0] latch_rdata;

	////////////////////////////////////////////////////////////
	// Keyboard path
	////////////////////////////////////////////////////////////

	ps2_receiver u_ps2_receiver (
		.CLK28   (CLK28),
		.rst     (rst),
		.ps2_clk (ps2_clk),
		.ps2_data(ps2_data),
		.rx_done (rx_done),
		.scancode(scancode)
	);

	key_matrix u_key_matrix (
		.CLK28   (CLK28),
		.rst     (rst),
		.rx_done (rx_done),
		.scancode(scancode),
		.row_sel (row_sel),
		.kbus_kbd(kbus_kbd),
		.keyreset(keyreset)
	);

	// Row selects come from the keyport
	keyport_6529 u_keyport_6529 (
		.CLK28     (CLK28),
		.rst       (rst),
		.addr      (addr),
		.wdata     (wdata),
		.rw        (rw),
		.bus_strobe(bus_strobe),
		.rdata     (keyport_rdata),
		.row_sel   (row_sel)
	);

	kbus_latch u_kbus_latch (
		.CLK28     (CLK28),
		.rst       (rst),
		.addr      (addr),
		.wdata     (wdata),
		.rw        (rw),
		.bus_strobe(bus_strobe),
		.joy0      (joy0),
		.joy1      (joy1),
		.kbus_kbd  (kbus_kbd),
		.kbus      (kbus),
		.rdata     (latch_rdata)
	);

	// Driven by rst and keyreset only, the other blocks stay on rst
	reset_stretch #(
		.RESET_CYCLES(RESET_CYCLES)
	) u_reset_stretch (
		.CLK28    (CLK28),
		.rst      (rst),
		.keyreset (keyreset),
		.sys_reset(sys_reset)
	);

	// Open bus, unselected sources float high
	assign rdata = keyport_rdata & latch_rdata;

endmodule

// File: hdl/c16_key_pkg.sv
package c16_key_pkg;

	////////////////////////////////////////////////////////////
	// State encodings
	////////////////////////////////////////////////////////////

	// PS/2 frame receiver, start bit is checked in idle
	typedef enum logic [1:0] {
		PS2_IDLE,
		PS2_DATA,
		PS2_PARITY,
		PS2_STOP
	} ps2_state_t;

	// Prefix tracking in the scancode decoder
	typedef enum logic [1:0] {
		SCAN_NORMAL,
		SCAN_BREAK,
		SCAN_EXT,
		SCAN_EXT_BREAK
	} scan_state_t;

	////////////////////////////////////////////////////////////
	// Set 2 scancodes with special meaning
	////////////////////////////////////////////////////////////

	localparam logic [7:0] SC_BREAK   = 8'hF0;
	localparam logic [7:0] SC_EXTEND  = 8'hE0;
	localparam logic [7:0] SC_LCTRL   = 8'h14;
	localparam logic [7:0] SC_LALT    = 8'h11;
	// Delete on the PC block, only valid after E0
	localparam logic [7:0] SC_DEL_EXT = 8'h71;

	// Result layout is {valid, row[2:0], col[2:0]}
	// Row is the keyport bit, col is the K line
	function automatic logic [6:0] key_pos(input logic [7:0] code, input logic ext);
		logic [6:0] pos;
		pos = '0;
		if (ext) begin
			// Only delete is taken from the extended set
			if (code == SC_DEL_EXT)
				pos = {1'b1, 3'd0, 3'd0};
		end else begin
			case (code)
				8'h66: pos = {1'b1, 3'd0, 3'd0};    // Backspace acts as INST/DEL
				8'h5A: pos = {1'b1, 3'd0, 3'd1};    // Return
				8'h26: pos = {1'b1, 3'd1, 3'd0};
				8'h1D: pos = {1'b1, 3'd1, 3'd1};
				8'h1C: pos = {1'b1, 3'd1, 3'd2};
				8'h25: pos = {1'b1, 3'd1, 3'd3};
				8'h1A: pos = {1'b1, 3'd1, 3'd4};
				8'h1B: pos = {1'b1, 3'd1, 3'd5};
				8'h24: pos = {1'b1, 3'd1, 3'd6};
				8'h12: pos = {1'b1, 3'd1, 3'd7};    // Both shifts share one key
				8'h59: pos = {1'b1, 3'd1, 3'd7};
				8'h2E: pos = {1'b1, 3'd2, 3'd0};
				8'h2D: pos = {1'b1, 3'd2, 3'd1};
				8'h23: pos = {1'b1, 3'd2, 3'd2};
				8'h36: pos = {1'b1, 3'd2, 3'd3};
				8'h21: pos = {1'b1, 3'd2, 3'd4};
				8'h2B: pos = {1'b1, 3'd2, 3'd5};
				8'h2C: pos = {1'b1, 3'd2, 3'd6};
				8'h22: pos = {1'b1, 3'd2, 3'd7};
				8'h3D: pos = {1'b1, 3'd3, 3'd0};
				8'h35: pos = {1'b1, 3'd3, 3'd1};
				8'h34: pos = {1'b1, 3'd3, 3'd2};
				8'h3E: pos = {1'b1, 3'd3, 3'd3};
				8'h32: pos = {1'b1, 3'd3, 3'd4};
				8'h33: pos = {1'b1, 3'd3, 3'd5};
				8'h3C: pos = {1'b1, 3'd3, 3'd6};
				8'h2A: pos = {1'b1, 3'd3, 3'd7};
				8'h46: pos = {1'b1, 3'd4, 3'd0};
				8'h43: pos = {1'b1, 3'd4, 3'd1};
				8'h3B: pos = {1'b1, 3'd4, 3'd2};
				8'h45: pos = {1'b1, 3'd4, 3'd3};
				8'h3A: pos = {1'b1, 3'd4, 3'd4};
				8'h42: pos = {1'b1, 3'd4, 3'd5};
				8'h44: pos = {1'b1, 3'd4, 3'd6};
				8'h31: pos = {1'b1, 3'd4, 3'd7};
				8'h4D: pos = {1'b1, 3'd5, 3'd1};
				8'h4B: pos = {1'b1, 3'd5, 3'd2};
				8'h16: pos = {1'b1, 3'd7, 3'd0};
				SC_LCTRL: pos = {1'b1, 3'd7, 3'd2};
				8'h1E: pos = {1'b1, 3'd7, 3'd3};
				8'h29: pos = {1'b1, 3'd7, 3'd4};    // Space
				SC_LALT: pos = {1'b1, 3'd7, 3'd5};  // Commodore key
				8'h15: pos = {1'b1, 3'd7, 3'd6};
				8'h76: pos = {1'b1, 3'd7, 3'd7};    // Esc as RUN/STOP
				default: pos = '0;
			endcase
		end
		return pos;
	endfunction

endpackage

// File: hdl/kbus_latch.sv
`timescale 1ns/100ps

module kbus_latch (
	input  logic                            CLK28,
	input  logic                            rst,
	input  logic [c16_bus_pkg::ADDR_W-1:0] addr,
	input  logic [c16_bus_pkg::DATA_W-1:0] wdata,
	input  logic                            rw,
	input  logic                            bus_strobe,
	input  logic [4:0]                      joy0,
	input  logic [4:0]                      joy1,
	input  logic [7:0]                      kbus_kbd,
	output logic [c16_bus_pkg::DATA_W-1:0] kbus,
	output logic [c16_bus_pkg::DATA_W-1:0] rdata
);
	import c16_bus_pkg::*;

	logic              latch_sel;
	logic [DATA_W-1:0] latch_q;
	// Per stick pull downs, {fire, up, down, left, right}
	logic [4:0]        joy0_k;
	logic [4:0]        joy1_k;

	assign latch_sel = (addr == KBD_LATCH_ADDR);

	always_ff @(posedge CLK28) begin
		if (rst)
			latch_q <= '1;
		else if (latch_sel && bus_strobe && !rw)
			latch_q <= wdata;
	end

	// Active low select, bit 2 for stick 0 and bit 1 for stick 1
	assign joy0_k = latch_q[2] ? 5'h1F : ~{joy0[4], joy0[0], joy0[1], joy0[2], joy0[3]};
	assign joy1_k = latch_q[1] ? 5'h1F : ~{joy1[4], joy1[0], joy1[1], joy1[2], joy1[3]};

	// Directions share K0..K3
	assign kbus[3:0] = kbus_kbd[3:0] & joy0_k[3:0] & joy1_k[3:0];
	// No joystick wiring on K4 and K5
	assign kbus[5:4] = kbus_kbd[5:4];
	// Each fire button has its own line
	assign kbus[6]   = kbus_kbd[6] & joy0_k[4];
	assign kbus[7]   = kbus_kbd[7] & joy1_k[4];

	assign rdata = latch_sel ? kbus : '1;

endmodule

// File: hdl/key_matrix.sv
`timescale 1ns/100ps

module key_matrix (
	input  logic       CLK28,
	input  logic       rst,
	input  logic       rx_done,
	input  logic [7:0] scancode,
	input  logic [7:0] row_sel,
	output logic [7:0] kbus_kbd,
	output logic       keyreset
);
	import c16_key_pkg::*;

	scan_state_t     state;
	// Pressed keys, indexed [row][col]
	logic [7:0][7:0] matrix;
	logic            ctrl_held;
	logic            alt_held;
	logic            is_ext;
	logic            is_brk;
	logic [6:0]      pos;
	logic            pos_valid;
	logic [2:0]      pos_row;
	logic [2:0]      pos_col;

	// Prefix flags decoded from the state
	assign is_ext = (state == SCAN_EXT) || (state == SCAN_EXT_BREAK);
	assign is_brk = (state == SCAN_BREAK) || (state == SCAN_EXT_BREAK);

	// Map the current byte onto the C16 matrix
	assign pos       = key_pos(scancode, is_ext);
	assign pos_valid = pos[6];
	assign pos_row   = pos[5:3];
	assign pos_col   = pos[2:0];

	////////////////////////////////////////////////////////////
	// Scancode sequence decoder
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK28) begin
		if (rst) begin
			state     <= SCAN_NORMAL;
			matrix    <= '0;
			ctrl_held <= 1'b0;
			alt_held  <= 1'b0;
			keyreset  <= 1'b0;
		end else begin
			keyreset <= 1'b0;
			if (rx_done) begin
				if (scancode == SC_EXTEND) begin
					state <= SCAN_EXT;
				end else if (scancode == SC_BREAK) begin
					// E0 F0 keeps the extended flag
					state <= is_ext ? SCAN_EXT_BREAK : SCAN_BREAK;
				end else begin
					state <= SCAN_NORMAL;
					// Make sets the key, break clears it
					if (pos_valid)
						matrix[pos_row][pos_col] <= !is_brk;
					// Modifiers for the reset combination
					if (!is_ext && scancode == SC_LCTRL)
						ctrl_held <= !is_brk;
					if (!is_ext && scancode == SC_LALT)
						alt_held <= !is_brk;
					if (is_ext && !is_brk && scancode == SC_DEL_EXT)
						keyreset <= ctrl_held && alt_held;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// K line drive
	////////////////////////////////////////////////////////////

	// Low row select enables that row, any pressed key in it pulls its column low
	always_comb begin
		kbus_kbd = '1;
		for (int r = 0; r < 8; r++) begin
			if (!row_sel[r])
				kbus_kbd = kbus_kbd & ~matrix[r];
		end
	end

endmodule

// File: hdl/keyport_6529.sv
`timescale 1ns/100ps

module keyport_6529 (
	input  logic                            CLK28,
	input  logic                            rst,
	input  logic [c16_bus_pkg::ADDR_W-1:0] addr,
	input  logic [c16_bus_pkg::DATA_W-1:0] wdata,
	input  logic                            rw,
	input  logic                            bus_strobe,
	output logic [c16_bus_pkg::DATA_W-1:0] rdata,
	output logic [c16_bus_pkg::DATA_W-1:0] row_sel
);
	import c16_bus_pkg::*;

	logic              port_sel;
	logic [DATA_W-1:0] port_q;

	// Whole $FD3x page is mirrored, as on the real board
	assign port_sel = (addr[ADDR_W-1:4] == KEYPORT_PAGE);

	// Output register, all rows deselected after reset
	always_ff @(posedge CLK28) begin
		if (rst)
			port_q <= '1;
		else if (port_sel && bus_strobe && !rw)
			port_q <= wdata;
	end

	assign row_sel = port_q;

	// Port is output only, so a read returns the register
	assign rdata = port_sel ? port_q : '1;

endmodule

// File: hdl/ps2_receiver.sv
`timescale 1ns/100ps

module ps2_receiver (
	input  logic       CLK28,
	input  logic       rst,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic       rx_done,
	output logic [7:0] scancode
);
	import c16_key_pkg::*;

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic [3:0] clk_hist;
	logic       clk_filt;
	logic       clk_fall;
	logic       frame_ok;
	ps2_state_t state;
	logic [2:0] bit_cnt;
	logic [7:0] shift_reg;
	logic       parity_bit;

	////////////////////////////////////////////////////////////
	// Line synchronizers and clock glitch filter
	////////////////////////////////////////////////////////////

	// Both lines idle high, so reset to ones
	always_ff @(posedge CLK28) begin
		if (rst) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_hist  <= 4'hF;
			clk_filt  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_hist  <= {clk_hist[2:0], clk_sync[1]};
			// Level only changes after four equal samples
			if (clk_hist == 4'hF)
				clk_filt <= 1'b1;
			else if (clk_hist == 4'h0)
				clk_filt <= 1'b0;
		end
	end

	// Single cycle strobe on the filtered falling edge
	assign clk_fall = clk_filt && (clk_hist == 4'h0);

	// Stop bit high and odd parity over data plus parity bit
	assign frame_ok = data_sync[1] && (^{parity_bit, shift_reg});

	////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK28) begin
		if (rst) begin
			state   <= PS2_IDLE;
			bit_cnt <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (clk_fall) begin
				case (state)
					PS2_IDLE: begin
						// Wait for a low start bit
						if (!data_sync[1]) begin
							state   <= PS2_DATA;
							bit_cnt <= '0;
						end
					end
					PS2_DATA: begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= PS2_PARITY;
					end
					PS2_PARITY: state <= PS2_STOP;
					PS2_STOP: begin
						rx_done <= frame_ok;
						state   <= PS2_IDLE;
					end
					default: state <= PS2_IDLE;
				endcase
			end
		end
	end

	// Data path, shifted in LSB first
	always_ff @(posedge CLK28) begin
		if (clk_fall) begin
			if (state == PS2_DATA)
				shift_reg <= {data_sync[1], shift_reg[7:1]};
			if (state == PS2_PARITY)
				parity_bit <= data_sync[1];
			if (state == PS2_STOP && frame_ok)
				scancode <= shift_reg;
		end
	end

endmodule

// File: hdl/reset_stretch.sv
`timescale 1ns/100ps

module reset_stretch #(
	parameter int unsigned RESET_CYCLES = c16_bus_pkg::RESET_CYCLES_DEF
) (
	input  logic CLK28,
	input  logic rst,
	input  logic keyreset,
	output logic sys_reset
);

	localparam int CNT_W = $clog2(RESET_CYCLES);

	logic [CNT_W-1:0] cnt;

	// Restart on the button or on Ctrl+Alt+Del, release when the count runs out
	always_ff @(posedge CLK28) begin
		if (rst || keyreset) begin
			cnt       <= '0;
			sys_reset <= 1'b1;
		end else if (cnt == CNT_W'(RESET_CYCLES - 1)) begin
			sys_reset <= 1'b0;
		end else begin
			cnt       <= cnt + 1'b1;
			sys_reset <= 1'b1;
		end
	end

endmodule

// File: test/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
	parameter int HALF_NS   = 20,
	parameter int RESET_LEN = 8
) (
	output logic CLK28,
	output logic rst
);

	// 40 ns period, first rising edge at 20 ns
	initial begin
		CLK28 = 1'b0;
		forever #(HALF_NS) CLK28 = ~CLK28;
	end

	// Reset spans RESET_LEN rising edges and drops on a falling edge
	initial begin
		rst = 1'b1;
		repeat (RESET_LEN) @(posedge CLK28);
		@(negedge CLK28);
		rst <= 1'b0;
	end

endmodule

// File: test/tb_c16_input.sv
`timescale 1ns/100ps

module tb_c16_input;
	import c16_bus_pkg::*;
	import c16_key_pkg::*;

	localparam int STRETCH      = 64;
	localparam int PS2_HALF     = 10;
	localparam int RST_WAIT     = 32;
	localparam int STRETCH_WAIT = 200;
	localparam int DONE_WAIT    = 40;
	localparam int PICK_TRIES   = 400;
	localparam logic [ADDR_W-1:0] KEYPORT_ADDR = {KEYPORT_PAGE, 4'h0};

	logic              CLK28;
	logic              rst;
	logic              ps2_clk;
	logic              ps2_data;
	logic [4:0]        joy0;
	logic [4:0]        joy1;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              rw;
	logic              bus_strobe;
	logic [DATA_W-1:0] rdata;
	logic              sys_reset;
	logic [DATA_W-1:0] kbus;
	logic [15:0]       lfsr_state;
	logic              cmp_en;
	// Reference state, [row][col] like the C16 matrix
	logic [7:0][7:0]   model_keys;
	logic [7:0]        model_rows;
	logic [7:0]        model_latch;
	int                run_len = 0;
	int                last_run = 0;

	clk_gen u_clk_gen (
		.CLK28(CLK28),
		.rst  (rst)
	);

	c16_input #(
		.RESET_CYCLES(STRETCH)
	) u_c16_input (
		.CLK28     (CLK28),
		.rst       (rst),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.joy0      (joy0),
		.joy1      (joy1),
		.addr      (addr),
		.wdata     (wdata),
		.rw        (rw),
		.bus_strobe(bus_strobe),
		.rdata     (rdata),
		.sys_reset (sys_reset),
		.kbus      (kbus)
	);

	////////////////////////////////////////////////////////////
	// Failure handling and random source
	////////////////////////////////////////////////////////////

	task automatic stop_run;
		$display("TB FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		stop_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			stop_run();
		end
	endtask

	// Galois form, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		int         i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
		return v;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model of matrix, keyport and latch
	////////////////////////////////////////////////////////////

	function automatic logic [7:0] ref_kbus(input logic [7:0][7:0] keys, input logic [7:0] rows,
			input logic [7:0] latch, input logic [4:0] j0, input logic [4:0] j1);
		logic [7:0] k;
		int         r;
		int         c;
		k = 8'hFF;
		// Selected rows are the low keyport bits
		for (r = 0; r < 8; r++)
			for (c = 0; c < 8; c++)
				if (!rows[r] && keys[r][c])
					k[c] = 1'b0;
		// K3..K0 pulled by up, down, left, right
		if (!latch[2]) begin
			k[3:0] = k[3:0] & ~{j0[0], j0[1], j0[2], j0[3]};
			k[6]   = k[6] & ~j0[4];
		end
		if (!latch[1]) begin
			k[3:0] = k[3:0] & ~{j1[0], j1[1], j1[2], j1[3]};
			k[7]   = k[7] & ~j1[4];
		end
		return k;
	endfunction

	task automatic apply_key(input logic [7:0] code, input logic ext, input logic make);
		logic [6:0] pos;
		pos = key_pos(code, ext);
		if (pos[6])
			model_keys[pos[5:3]][pos[2:0]] = make;
	endtask

	// Random mapped code, optionally one whose key is still up
	task automatic pick_code(input logic need_free, output logic [7:0] code);
		logic [6:0] pos;
		int         tries;
		tries = 0;
		do begin
			code = rand_bits(8);
			pos = key_pos(code, 1'b0);
			tries++;
		end while ((!pos[6] || (need_free && model_keys[pos[5:3]][pos[2:0]]))
			&& tries < PICK_TRIES);
		if (!pos[6] || (need_free && model_keys[pos[5:3]][pos[2:0]]))
			abort_run("no usable scancode found in the random sequence");
	endtask

	////////////////////////////////////////////////////////////
	// Bus and PS/2 host
	////////////////////////////////////////////////////////////

	task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		addr       = a;
		wdata      = d;
		rw         = 1'b0;
		bus_strobe = 1'b1;
		@(negedge CLK28);
		bus_strobe = 1'b0;
		rw         = 1'b1;
	endtask

	// rdata is combinational, sampled a full cycle after addr settles
	task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
		addr       = a;
		rw         = 1'b1;
		bus_strobe = 1'b0;
		@(negedge CLK28);
		d = rdata;
	endtask

	// Device side frame, data changes while the PS/2 clock is high
	task automatic send_frame(input logic [7:0] code, input logic good_parity,
			output logic seen);
		logic [10:0] bits;
		logic        par;
		int          i;
		int          h;
		int          n;
		par = ~^code;
		if (!good_parity)
			par = ~par;
		// Start, eight data bits LSB first, odd parity, stop
		bits = {1'b1, par, code, 1'b0};
		seen = 1'b0;
		for (i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			repeat (PS2_HALF) @(negedge CLK28);
			ps2_clk = 1'b0;
			for (h = 0; h < PS2_HALF; h++) begin
				@(negedge CLK28);
				if (u_c16_input.rx_done)
					seen = 1'b1;
			end
			ps2_clk = 1'b1;
		end
		// Filter delay varies, keep watching after release
		n = 0;
		while (!seen && n < DONE_WAIT) begin
			@(negedge CLK28);
			if (u_c16_input.rx_done)
				seen = 1'b1;
			n++;
		end
		// Matrix follows rx_done by one edge
		repeat (2) @(negedge CLK28);
	endtask

	task automatic send_byte(input logic [7:0] code);
		logic seen;
		send_frame(code, 1'b1, seen);
		if (!seen)
			abort_run("no rx_done after a PS/2 frame with good parity");
	endtask

	// Opens the kbus comparison for a few edges
	task automatic hold_compare;
		cmp_en = 1'b1;
		repeat (3) @(negedge CLK28);
		cmp_en = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Comparison and sys_reset monitor
	////////////////////////////////////////////////////////////

	always @(posedge CLK28) begin
		if (cmp_en)
			check_value("kbus", kbus, ref_kbus(model_keys, model_rows, model_latch, joy0, joy1));
	end

	// Length of the last finished high phase of sys_reset
	always @(negedge CLK28) begin
		if (sys_reset) begin
			run_len <= run_len + 1;
		end else if (run_len != 0) begin
			last_run <= run_len;
			run_len  <= 0;
		end
	end

	initial begin
		logic [7:0] d;
		logic [7:0] rd;
		logic [7:0] code;
		logic [7:0] latch_val;
		logic       seen;
		logic [7:0] made[$];
		int         n;
		int         i;
		int         j;
		ps2_clk     = 1'b1;
		ps2_data    = 1'b1;
		joy0        = '0;
		joy1        = '0;
		addr        = '0;
		wdata       = '0;
		rw          = 1'b1;
		bus_strobe  = 1'b0;
		cmp_en      = 1'b0;
		lfsr_state  = 16'd12;
		model_keys  = '0;
		model_rows  = 8'hFF;
		model_latch = 8'hFF;

		// Reset release, rst drops one edge before the first low sample
		n = 0;
		@(negedge CLK28);
		while (rst && n < RST_WAIT) begin
			@(negedge CLK28);
			n++;
		end
		if (rst)
			abort_run("reset from clk_gen was never released");
		n = 1;
		while (sys_reset && n < STRETCH_WAIT) begin
			@(negedge CLK28);
			n++;
		end
		if (sys_reset)
			abort_run("sys_reset did not fall after reset");
		check_value("sys_reset cycles after rst", n, STRETCH);
		bus_read(KEYPORT_ADDR, rd);
		check_value("rdata at FD30", rd, 8'hFF);
		bus_read(KBD_LATCH_ADDR, rd);
		check_value("rdata at FF08", rd, 8'hFF);

		// Keyport read back, also through the page mirror
		for (i = 0; i < 4; i++) begin
			d = rand_bits(8);
			bus_write(KEYPORT_ADDR, d);
			model_rows = d;
			bus_read(KEYPORT_ADDR | 16'h000F, rd);
			check_value("keyport rdata", rd, d);
		end

		// Random makes under random row selects
		for (i = 0; i < 12; i++) begin
			d = rand_bits(8);
			bus_write(KEYPORT_ADDR, d);
			model_rows = d;
			pick_code(1'b0, code);
			send_byte(code);
			apply_key(code, 1'b0, 1'b1);
			made.push_back(code);
			hold_compare();
		end
		bus_write(KEYPORT_ADDR, 8'h00);
		model_rows = 8'h00;
		hold_compare();

		// Bad parity on a key that is still up
		pick_code(1'b1, code);
		send_frame(code, 1'b0, seen);
		if (seen)
			abort_run("rx_done pulsed for a frame with bad parity");
		hold_compare();

		// Break every key again
		foreach (made[k]) begin
			send_byte(SC_BREAK);
			send_byte(made[k]);
			apply_key(made[k], 1'b0, 1'b0);
			hold_compare();
		end

		// Joysticks over one held key, all latch selects
		send_byte(8'h1C);
		apply_key(8'h1C, 1'b0, 1'b1);
		for (i = 0; i < 4; i++) begin
			latch_val = {5'b11111, 2'(i), 1'b1};
			bus_write(KBD_LATCH_ADDR, latch_val);
			model_latch = latch_val;
			for (j = 0; j < 4; j++) begin
				joy0 = 5'(rand_bits(5));
				joy1 = 5'(rand_bits(5));
				hold_compare();
				bus_read(KBD_LATCH_ADDR, rd);
				check_value("rdata at FF08", rd,
					ref_kbus(model_keys, model_rows, model_latch, joy0, joy1));
			end
		end

		// Ctrl, Alt, then E0 71
		joy0 = '0;
		joy1 = '0;
		bus_write(KBD_LATCH_ADDR, 8'hFF);
		model_latch = 8'hFF;
		send_byte(SC_LCTRL);
		apply_key(SC_LCTRL, 1'b0, 1'b1);
		send_byte(SC_LALT);
		apply_key(SC_LALT, 1'b0, 1'b1);
		if (sys_reset)
			abort_run("sys_reset rose before delete was pressed");
		send_byte(SC_EXTEND);
		send_byte(SC_DEL_EXT);
		apply_key(SC_DEL_EXT, 1'b1, 1'b1);
		n = 0;
		while (!sys_reset && n < DONE_WAIT) begin
			@(negedge CLK28);
			n++;
		end
		if (!sys_reset)
			abort_run("sys_reset did not rise after Ctrl+Alt+Del");
		n = 0;
		while (sys_reset && n < STRETCH_WAIT) begin
			@(negedge CLK28);
			n++;
		end
		if (sys_reset)
			abort_run("sys_reset stayed high after Ctrl+Alt+Del");
		@(negedge CLK28);
		check_value("sys_reset cycles after keyreset", last_run, STRETCH);
		// Held keys survive the system reset
		hold_compare();

		$display("TB PASSED");
		$finish;
	end

endmodule
